/* include/boot_program.svh */
`ifndef BOOT_PROGRAM_SVH
`define BOOT_PROGRAM_SVH

// fibonacci boot program
// r0 current value, r1 previous value, r2 loop count, r3 scratch
localparam instr_t BOOT_ROM [ROM_DEPTH] = '{
    0:  instr_t'{OP_LDI,  2'd0, 2'd0, 8'd1},
    1:  instr_t'{OP_LDI,  2'd1, 2'd0, 8'd0},
    2:  instr_t'{OP_LDI,  2'd2, 2'd0, 8'd12},
    // loop head
    3:  instr_t'{OP_ST,   2'd0, 2'd0, DISPLAY_ADDR},
    // count goes to an address the display drops
    4:  instr_t'{OP_ST,   2'd0, 2'd2, 8'h20},
    // keep old r0 for the shift into r1
    5:  instr_t'{OP_MOV,  2'd3, 2'd0, 8'd0},
    6:  instr_t'{OP_ADD,  2'd0, 2'd1, 8'd0},
    7:  instr_t'{OP_MOV,  2'd1, 2'd3, 8'd0},
    // decrement by adding all ones
    8:  instr_t'{OP_ADDI, 2'd2, 2'd0, 8'hff},
    9:  instr_t'{OP_JNZ,  2'd0, 2'd2, 8'd3},
    10: instr_t'{OP_HALT, 2'd0, 2'd0, 8'd0},
    // unused words halt too
    default: instr_t'{OP_HALT, 2'd0, 2'd0, 8'd0}
};

`endif

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // datapath and bus widths
    localparam int DATA_W    = 8;
    localparam int ADDR_W    = 8;
    localparam int REG_W     = 2;
    localparam int NUM_REGS  = 1 << REG_W;

    // instruction rom size and program counter width
    localparam int ROM_DEPTH = 16;
    localparam int PC_W      = $clog2(ROM_DEPTH);

    // memory mapped address shown on the two digits
    localparam logic [ADDR_W-1:0] DISPLAY_ADDR = 8'h14;

    // halt is zero so an empty rom word stops the core
    typedef enum logic [3:0] {
        OP_HALT = 4'h0,
        OP_LDI  = 4'h1,
        OP_ADD  = 4'h2,
        OP_ADDI = 4'h3,
        OP_MOV  = 4'h4,
        OP_ST   = 4'h5,
        OP_JNZ  = 4'h6
    } opcode_t;

    // one 16 bit instruction word
    typedef struct packed {
        opcode_t           op;
        logic [REG_W-1:0]  rd;
        logic [REG_W-1:0]  rs;
        // immediate, store address or jump target
        logic [DATA_W-1:0] imm;
    } instr_t;

    // a single memory mapped write
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } store_rec_t;

endpackage

/* rtl/board_pkg.sv */
package board_pkg;

    // store buffer size, also the cpu's starting credit count
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // enable ticks each shown value is held
    localparam int HOLD_TICKS = 4;
    localparam int HOLD_W     = $clog2(HOLD_TICKS + 1);

    // flops in the reset button synchronizer
    localparam int RESET_SYNC_STAGES = 2;

    // segments A..G from msb to lsb, active low
    typedef logic [6:0] seg7_t;

    localparam seg7_t BLANK_SEG = 7'h7f;

    // standard hex digit patterns
    function automatic seg7_t hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'h01;
            4'h1: return 7'h4f;
            4'h2: return 7'h12;
            4'h3: return 7'h06;
            4'h4: return 7'h4c;
            4'h5: return 7'h24;
            4'h6: return 7'h20;
            4'h7: return 7'h0f;
            4'h8: return 7'h00;
            4'h9: return 7'h04;
            4'ha: return 7'h08;
            4'hb: return 7'h60;
            4'hc: return 7'h31;
            4'hd: return 7'h42;
            4'he: return 7'h30;
            default: return 7'h38;
        endcase
    endfunction

endpackage

/* rtl/cpu_main.sv */
`timescale 1ns/1ps

module cpu_main (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_exec_en,
    input  logic                i_credit,
    output cpu_pkg::store_rec_t o_store,
    output logic                o_store_valid,
    output logic                o_halted
);
    import cpu_pkg::*;
    import board_pkg::*;

    `include "boot_program.svh"

    // architectural state
    logic [PC_W-1:0]       pc;
    logic [DATA_W-1:0]     regs [NUM_REGS];

    // free slots left in the store buffer
    logic [FIFO_CNT_W-1:0] credits;

    // decode helpers
    instr_t                instr;
    logic [DATA_W-1:0]     rd_val;
    logic [DATA_W-1:0]     rs_val;
    logic                  step;
    logic                  st_stall;
    logic                  spend;

    always_comb begin
        // rom read is asynchronous
        instr    = BOOT_ROM[pc];
        rd_val   = regs[instr.rd];
        rs_val   = regs[instr.rs];
        // nothing executes once halted
        step     = i_exec_en && !o_halted;
        // store with no credit left waits
        st_stall = (instr.op == OP_ST) && (credits == '0);
        spend    = step && (instr.op == OP_ST) && !st_stall;
    end

    // store record leaves in the same cycle the credit is spent
    assign o_store_valid = spend;
    assign o_store       = '{addr: instr.imm, data: rs_val};

    always_ff @(posedge clk) begin
        if (reset) begin
            // buffer starts empty
            credits <= FIFO_CNT_W'(FIFO_DEPTH);
        end else begin
            case ({spend, i_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                // spend and return together cancel
                default: credits <= credits;
            endcase
        end
    end

    // program counter and halt flag
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= '0;
            o_halted <= 1'b0;
        end else if (step) begin
            case (instr.op)
                OP_HALT: begin
                    // pc parks on the halt word
                    o_halted <= 1'b1;
                end
                OP_JNZ: begin
                    if (rs_val != '0) begin
                        pc <= instr.imm[PC_W-1:0];
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                OP_ST: begin
                    // stalled store retries on the next enable
                    if (!st_stall) begin
                        pc <= pc + 1'b1;
                    end
                end
                default: begin
                    pc <= pc + 1'b1;
                end
            endcase
        end
    end

    // register file writeback
    always_ff @(posedge clk) begin
        if (step) begin
            case (instr.op)
                OP_LDI: begin
                    regs[instr.rd] <= instr.imm;
                end
                OP_ADD: begin
                    regs[instr.rd] <= rd_val + rs_val;
                end
                OP_ADDI: begin
                    // wraps at 8 bits, 0xff acts as minus one
                    regs[instr.rd] <= rd_val + instr.imm;
                end
                OP_MOV: begin
                    regs[instr.rd] <= rs_val;
                end
                default: begin
                    // st, jnz and halt leave registers alone
                end
            endcase
        end
    end

endmodule

/* rtl/store_fifo.sv */
`timescale 1ns/1ps

module store_fifo (
    input  logic                clk,
    input  logic                reset,
    input  cpu_pkg::store_rec_t i_store,
    input  logic                i_store_valid,
    input  logic                i_take,
    output cpu_pkg::store_rec_t o_head,
    output logic                o_head_valid,
    output logic                o_credit
);
    import cpu_pkg::*;
    import board_pkg::*;

    // record storage
    store_rec_t            mem [FIFO_DEPTH];

    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  push;
    logic                  pop;

    // the credit scheme keeps writes away from a full buffer
    assign push = i_store_valid;
    // ignore a take against an empty buffer
    assign pop  = i_take && o_head_valid;

    // head is visible the cycle after its write
    assign o_head       = mem[rd_ptr];
    assign o_head_valid = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_store;
        end
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per record taken
            o_credit <= pop;
        end
    end

endmodule

/* rtl/hex_display.sv */
`timescale 1ns/1ps

module hex_display (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_exec_en,
    input  cpu_pkg::store_rec_t i_head,
    input  logic                i_head_valid,
    output logic                o_take,
    output board_pkg::seg7_t    o_seg_high,
    output board_pkg::seg7_t    o_seg_low
);
    import cpu_pkg::*;
    import board_pkg::*;

    typedef enum logic [0:0] {
        DISP_IDLE,
        DISP_HOLD
    } disp_state_t;

    disp_state_t       state;
    logic [HOLD_W-1:0] hold_cnt;
    logic              is_disp;

    // last shown byte
    logic [DATA_W-1:0] value;
    // digits stay blank until the first display store
    logic              shown;

    assign is_disp = (i_head.addr == DISPLAY_ADDR);

    // pop whenever idle, other addresses are simply discarded
    assign o_take = (state == DISP_IDLE) && i_head_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DISP_IDLE;
            hold_cnt <= '0;
            shown    <= 1'b0;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (o_take && is_disp) begin
                        state    <= DISP_HOLD;
                        hold_cnt <= HOLD_W'(HOLD_TICKS);
                        shown    <= 1'b1;
                    end
                end
                DISP_HOLD: begin
                    // count enable ticks, not clocks
                    if (i_exec_en) begin
                        hold_cnt <= hold_cnt - 1'b1;
                        if (hold_cnt == HOLD_W'(1)) begin
                            state <= DISP_IDLE;
                        end
                    end
                end
                default: begin
                    state <= DISP_IDLE;
                end
            endcase
        end
    end

    // latch the byte on the take
    always_ff @(posedge clk) begin
        if (o_take && is_disp) begin
            value <= i_head.data;
        end
    end

    // nibble decode
    assign o_seg_high = shown ? hex_to_seg(value[7:4]) : BLANK_SEG;
    assign o_seg_low  = shown ? hex_to_seg(value[3:0]) : BLANK_SEG;

endmodule

/* rtl/cpusys_board.sv */
`timescale 1ns/1ps

module cpusys_board #(
    parameter int CLK_DIV_BITS = 20
) (
    input  logic             clk,
    input  logic             reset,
    output logic             o_halt_led,
    output board_pkg::seg7_t o_segment1,
    output board_pkg::seg7_t o_segment2
);
    import cpu_pkg::*;
    import board_pkg::*;

    // button synchronizer chain, msb is the internal reset
    logic [RESET_SYNC_STAGES-1:0] reset_sync;
    logic                         sys_reset;

    // execute enable divider
    logic [CLK_DIV_BITS-1:0]      div_cnt;
    logic                         exec_en;

    // cpu to buffer
    store_rec_t                   store;
    logic                         store_valid;
    logic                         credit;

    // buffer to display
    store_rec_t                   head;
    logic                         head_valid;
    logic                         take;

    logic                         halted;

    always_ff @(posedge clk) begin
        reset_sync <= {reset_sync[RESET_SYNC_STAGES-2:0], reset};
    end

    assign sys_reset = reset_sync[RESET_SYNC_STAGES-1];

    // one pulse every 2^CLK_DIV_BITS clocks
    always_ff @(posedge clk) begin
        if (sys_reset) begin
            div_cnt <= '0;
            exec_en <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            exec_en <= (div_cnt == '0);
        end
    end

    cpu_main u_cpu_main (
        .clk           (clk),
        .reset         (sys_reset),
        .i_exec_en     (exec_en),
        .i_credit      (credit),
        .o_store       (store),
        .o_store_valid (store_valid),
        .o_halted      (halted)
    );

    store_fifo u_store_fifo (
        .clk           (clk),
        .reset         (sys_reset),
        .i_store       (store),
        .i_store_valid (store_valid),
        .i_take        (take),
        .o_head        (head),
        .o_head_valid  (head_valid),
        .o_credit      (credit)
    );

    // segment1 is the high digit
    hex_display u_hex_display (
        .clk          (clk),
        .reset        (sys_reset),
        .i_exec_en    (exec_en),
        .i_head       (head),
        .i_head_valid (head_valid),
        .o_take       (take),
        .o_seg_high   (o_segment1),
        .o_seg_low    (o_segment2)
    );

    // led lights once the core halts
    assign o_halt_led = halted;

endmodule

/* verification/cpusys_props.sv */
`timescale 1ns/1ps

module cpusys_props (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            i_store_valid,
    input  logic                            i_credit,
    input  logic                            i_take,
    input  logic                            i_head_valid,
    input  logic [board_pkg::FIFO_CNT_W-1:0] i_credits,
    input  logic [board_pkg::FIFO_CNT_W-1:0] i_fifo_count
);
    import board_pkg::*;

    // failures so far, read by the testbench
    int   err_count = 0;
    // signals are meaningless before the first internal reset
    logic armed = 1'b0;

    always @(posedge clk) begin
        if (reset) begin
            armed <= 1'b1;
        end
    end

    // credit counter bounded by the buffer size
    credit_max: assert property (@(posedge clk) disable iff (reset || !armed)
        i_credits <= FIFO_CNT_W'(FIFO_DEPTH))
    else begin
        $error("credit count above the buffer depth");
        err_count = err_count + 1;
    end

    // a store needs a credit in hand
    store_has_credit: assert property (@(posedge clk) disable iff (reset || !armed)
        i_store_valid |-> (i_credits != '0))
    else begin
        $error("store issued with no credit left");
        err_count = err_count + 1;
    end

    no_take_empty: assert property (@(posedge clk) disable iff (reset || !armed)
        i_take |-> i_head_valid)
    else begin
        $error("take pulsed while the buffer head was not valid");
        err_count = err_count + 1;
    end

    no_write_full: assert property (@(posedge clk) disable iff (reset || !armed)
        i_store_valid |-> (i_fifo_count < FIFO_CNT_W'(FIFO_DEPTH)))
    else begin
        $error("write reached a full store buffer");
        err_count = err_count + 1;
    end

    // credits held, records queued and a credit in flight always add up to the depth
    credit_conserved: assert property (@(posedge clk) disable iff (reset || !armed)
        (int'(i_credits) + int'(i_fifo_count) + int'(i_credit)) == FIFO_DEPTH)
    else begin
        $error("credits and buffered records out of balance");
        err_count = err_count + 1;
    end

endmodule

/* verification/tb_cpusys_board.sv */
`timescale 1ns/1ps

module tb_cpusys_board;
    import cpu_pkg::*;
    import board_pkg::*;

    localparam int CLK_DIV_BITS = 3;
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_VALUES   = 12;
    // clocks between execute enables
    localparam int ENABLE_CLKS  = 1 << CLK_DIV_BITS;
    // 12 values, each worst case HOLD_TICKS x 8 enable periods, plus margin
    localparam int TIMEOUT_NS   = NUM_VALUES * HOLD_TICKS * 8 * ENABLE_CLKS * CLK_PERIOD
                                  + 200 * CLK_PERIOD;

    logic        clk;
    logic        reset;
    logic        halt_led;
    seg7_t       seg_high;
    seg7_t       seg_low;

    // reference fibonacci model
    logic [7:0]  fib_cur;
    logic [7:0]  fib_prev;
    int          shown_cnt;
    logic [13:0] last_pair;
    logic        halt_seen;
    logic        checking;
    // a display record was taken, new digits due next cycle
    logic        update_due;

    // protocol checks on the cpu, buffer and display links
    bind cpusys_board cpusys_props u_props (
        .clk           (clk),
        .reset         (sys_reset),
        .i_store_valid (store_valid),
        .i_credit      (credit),
        .i_take        (take),
        .i_head_valid  (head_valid),
        .i_credits     (u_cpu_main.credits),
        .i_fifo_count  (u_store_fifo.count)
    );

    cpusys_board #(
        .CLK_DIV_BITS (CLK_DIV_BITS)
    ) u_cpusys_board (
        .clk        (clk),
        .reset      (reset),
        .o_halt_led (halt_led),
        .o_segment1 (seg_high),
        .o_segment2 (seg_low)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    // inverse of the standard active low hex table, -1 if not a digit
    function automatic int seg_to_nibble(input seg7_t seg);
        case (seg)
            7'h01: return 0;
            7'h4f: return 1;
            7'h12: return 2;
            7'h06: return 3;
            7'h4c: return 4;
            7'h24: return 5;
            7'h20: return 6;
            7'h0f: return 7;
            7'h00: return 8;
            7'h04: return 9;
            7'h08: return 10;
            7'h60: return 11;
            7'h31: return 12;
            7'h42: return 13;
            7'h30: return 14;
            7'h38: return 15;
            default: return -1;
        endcase
    endfunction

    // outputs sampled mid cycle, away from the rising edge
    always @(negedge clk) begin
        int         hi;
        int         lo;
        logic [7:0] value;
        if (checking) begin
            assert (u_cpusys_board.u_props.err_count == 0) else begin
                $display("a bus protocol assertion fired in cpusys_props");
                abort_run();
            end
            if (update_due) begin
                hi = seg_to_nibble(seg_high);
                lo = seg_to_nibble(seg_low);
                assert (hi >= 0 && lo >= 0) else begin
                    $display("illegal segment pattern %h %h", seg_high, seg_low);
                    abort_run();
                end
                assert (shown_cnt < NUM_VALUES) else begin
                    $display("display changed after the last value");
                    abort_run();
                end
                value = {hi[3:0], lo[3:0]};
                // repeated values still count, one per display store
                check_value("fib_sequence", fib_cur, value);
                check_value("halt_before_last", 0, halt_led);
                {fib_cur, fib_prev} = {fib_cur + fib_prev, fib_cur};
                shown_cnt = shown_cnt + 1;
                last_pair = {seg_high, seg_low};
            end else if (shown_cnt == 0) begin
                // blank until the first display store
                check_value("reset_blank", {BLANK_SEG, BLANK_SEG}, {seg_high, seg_low});
            end else begin
                // a shown 0x20 store would move the digits here
                check_value("segments_steady", last_pair, {seg_high, seg_low});
            end
            // digits follow one cycle after the take
            update_due = u_cpusys_board.take
                         && (u_cpusys_board.head.addr == DISPLAY_ADDR);
            if (halt_seen) begin
                check_value("halt_held", 1, halt_led);
            end
            if (halt_led) begin
                check_value("halt_after_last", NUM_VALUES, shown_cnt);
                halt_seen = 1'b1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: display sequence and halt not done after %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial begin
        reset      = 1'b1;
        checking   = 1'b0;
        update_due = 1'b0;
        shown_cnt  = 0;
        fib_cur    = 8'd1;
        fib_prev   = 8'd0;
        halt_seen  = 1'b0;
        last_pair  = {BLANK_SEG, BLANK_SEG};
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        checking <= 1'b1;
        wait (shown_cnt == NUM_VALUES && halt_led);
        // keep watching for a late change or a dropped led
        repeat (4 * HOLD_TICKS * ENABLE_CLKS) @(negedge clk);
        if (u_cpusys_board.u_props.err_count == 0 && shown_cnt == NUM_VALUES && halt_led) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

/* sources.f */
+incdir+include
rtl/cpu_pkg.sv
rtl/board_pkg.sv
rtl/cpu_main.sv
rtl/store_fifo.sv
rtl/hex_display.sv
rtl/cpusys_board.sv
verification/cpusys_props.sv
verification/tb_cpusys_board.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
    --top-module tb_cpusys_board -Mdir obj_dir -o sim_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed"
    exit "$status"
fi

# let the testbench see assertion errors and end the run itself
./obj_dir/sim_tb +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished"
exit 0
